/* source/ewb_pkg.sv */
package ewb_pkg;

    // number of buffered lines.
    localparam int EWB_DEPTH = 8;

    // cache line width in bits.
    localparam int LINE_WIDTH = 256;

    // entry index width, log2 of the depth.
    localparam int PTR_WIDTH = 3;

    // lowest address bit of the line tag.
    localparam int TAG_LSB = 5;

    // one full cache line.
    typedef logic [LINE_WIDTH-1:0] line_t;

    // byte address from the core.
    typedef logic [31:0] addr_t;

    // line tag, address bits above the line offset.
    typedef logic [31-TAG_LSB:0] tag_t;

    // index of one entry.
    typedef logic [PTR_WIDTH-1:0] ptr_t;

    // one bit per entry.
    typedef logic [EWB_DEPTH-1:0] entry_mask_t;

endpackage : ewb_pkg

/* source/ewb_entry.sv */
`timescale 1ns/10ps

module ewb_entry (
    input  logic           clk,
    input  logic           rst,

    // fill from the allocator.
    input  logic           load_i,
    input  ewb_pkg::line_t data_i,
    input  ewb_pkg::addr_t addr_i,

    // release from the drain unit.
    input  logic           clear_i,

    // tag lookup and in-place replace.
    input  logic           tag_check_i,
    input  ewb_pkg::tag_t  tag_i,
    input  logic           write_i,
    input  ewb_pkg::line_t replace_i,

    output logic           valid_o,
    output logic           match_o,
    output ewb_pkg::line_t data_o,
    output ewb_pkg::addr_t addr_o
);

    import ewb_pkg::*;

    logic  valid_q;
    line_t data_q;
    addr_t addr_q;
    tag_t  stored_tag;

    assign stored_tag = addr_q[31:TAG_LSB];

    // only a live line can hit.
    assign match_o = valid_q && tag_check_i && (stored_tag == tag_i);

    // slot occupancy.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end
    end

    // line payload, written on a fill or a replace hit.
    always_ff @(posedge clk) begin
        if (load_i) begin
            data_q <= data_i;
        end else if (match_o && write_i) begin
            data_q <= replace_i;
        end
    end

    // address is only written on a fill.
    always_ff @(posedge clk) begin
        if (load_i) begin
            addr_q <= addr_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;
    assign addr_o  = addr_q;

endmodule : ewb_entry

/* source/ewb_alloc.sv */
`timescale 1ns/10ps

module ewb_alloc (
    input  logic                 clk,
    input  logic                 rst,

    // push request from the cache.
    input  logic                 valid_i,

    // current occupancy of every slot.
    input  ewb_pkg::entry_mask_t entry_valid_i,

    output logic                 full_o,
    output ewb_pkg::entry_mask_t load_mask_o,
    output ewb_pkg::ptr_t        write_ptr_o
);

    import ewb_pkg::*;

    ptr_t write_ptr;
    ptr_t write_ptr_next;
    logic push;

    // the next slot to fill is still occupied.
    assign full_o = entry_valid_i[write_ptr];
    assign push   = valid_i && !full_o;

    assign write_ptr_next = (write_ptr == ptr_t'(EWB_DEPTH - 1)) ? '0 : write_ptr + 1'b1;

    // one-hot fill strobe for the slot at the pointer.
    always_comb begin
        load_mask_o = '0;
        if (push) begin
            load_mask_o[write_ptr] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            write_ptr <= '0;
        end else if (push) begin
            write_ptr <= write_ptr_next;
        end
    end

    assign write_ptr_o = write_ptr;

endmodule : ewb_alloc

/* source/ewb_drain.sv */
`timescale 1ns/10ps

module ewb_drain (
    input  logic                 clk,
    input  logic                 rst,

    // memory side takes the head.
    input  logic                 yumi_i,

    // state of every slot.
    input  ewb_pkg::entry_mask_t entry_valid_i,
    input  ewb_pkg::line_t       entry_data_i [ewb_pkg::EWB_DEPTH],
    input  ewb_pkg::addr_t       entry_addr_i [ewb_pkg::EWB_DEPTH],

    output logic                 empty_o,
    output ewb_pkg::line_t       data_o,
    output ewb_pkg::addr_t       addr_o,
    output ewb_pkg::entry_mask_t clear_mask_o
);

    import ewb_pkg::*;

    ptr_t read_ptr;
    ptr_t read_ptr_next;
    logic pop;

    // head slot holds nothing.
    assign empty_o = !entry_valid_i[read_ptr];

    // yumi on an empty buffer is dropped.
    assign pop = yumi_i && !empty_o;

    assign read_ptr_next = (read_ptr == ptr_t'(EWB_DEPTH - 1)) ? '0 : read_ptr + 1'b1;

    // oldest line goes out.
    assign data_o = entry_data_i[read_ptr];
    assign addr_o = entry_addr_i[read_ptr];

    // one-hot release of the head slot.
    always_comb begin
        clear_mask_o = '0;
        if (pop) begin
            clear_mask_o[read_ptr] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_ptr <= '0;
        end else if (pop) begin
            read_ptr <= read_ptr_next;
        end
    end

endmodule : ewb_drain

/* source/ewb_lookup.sv */
`timescale 1ns/10ps

module ewb_lookup (
    // per-slot tag hits, already qualified by valid.
    input  ewb_pkg::entry_mask_t entry_match_i,

    // next slot to fill; the youngest line sits just below it.
    input  ewb_pkg::ptr_t        write_ptr_i,

    input  ewb_pkg::line_t       entry_data_i [ewb_pkg::EWB_DEPTH],

    output logic                 hit_o,
    output ewb_pkg::line_t       read_o
);

    import ewb_pkg::*;

    // scan from oldest to youngest so the youngest hit is kept.
    always_comb begin
        ptr_t idx;
        hit_o  = 1'b0;
        read_o = '0;
        idx    = write_ptr_i;
        for (int k = 0; k < EWB_DEPTH; k++) begin
            if (entry_match_i[idx]) begin
                hit_o  = 1'b1;
                read_o = entry_data_i[idx];
            end
            idx = (idx == ptr_t'(EWB_DEPTH - 1)) ? '0 : idx + 1'b1;
        end
    end

endmodule

/* source/evict_buffer.sv */
`timescale 1ns/10ps

module evict_buffer (
    input  logic           clk,
    input  logic           rst,

    // eviction push from the cache.
    input  logic           valid_i,
    input  ewb_pkg::line_t data_i,
    input  ewb_pkg::addr_t addr_i,
    output logic           full_o,

    // lookup and replace from the cache.
    input  logic           tag_check_i,
    input  ewb_pkg::tag_t  tag_i,
    input  logic           write_ewb_i,
    input  ewb_pkg::line_t replace_i,
    output logic           hit_o,
    output ewb_pkg::line_t read_o,

    // drain to memory.
    output logic           empty_o,
    output ewb_pkg::line_t data_o,
    output ewb_pkg::addr_t addr_o,
    input  logic           yumi_i
);

    import ewb_pkg::*;

    entry_mask_t load_mask;
    entry_mask_t clear_mask;
    entry_mask_t entry_valid;
    entry_mask_t entry_match;
    ptr_t        write_ptr;
    line_t       entry_data [EWB_DEPTH];
    addr_t       entry_addr [EWB_DEPTH];

    // fill side.
    ewb_alloc i_alloc (
        .clk           (clk),
        .rst           (rst),
        .valid_i       (valid_i),
        .entry_valid_i (entry_valid),
        .full_o        (full_o),
        .load_mask_o   (load_mask),
        .write_ptr_o   (write_ptr)
    );

    // storage slots.
    for (genvar g = 0; g < EWB_DEPTH; g++) begin : g_entry
        ewb_entry i_entry (
            .clk         (clk),
            .rst         (rst),
            .load_i      (load_mask[g]),
            .data_i      (data_i),
            .addr_i      (addr_i),
            .clear_i     (clear_mask[g]),
            .tag_check_i (tag_check_i),
            .tag_i       (tag_i),
            .write_i     (write_ewb_i),
            .replace_i   (replace_i),
            .valid_o     (entry_valid[g]),
            .match_o     (entry_match[g]),
            .data_o      (entry_data[g]),
            .addr_o      (entry_addr[g])
        );
    end

    // memory side.
    ewb_drain i_drain (
        .clk           (clk),
        .rst           (rst),
        .yumi_i        (yumi_i),
        .entry_valid_i (entry_valid),
        .entry_data_i  (entry_data),
        .entry_addr_i  (entry_addr),
        .empty_o       (empty_o),
        .data_o        (data_o),
        .addr_o        (addr_o),
        .clear_mask_o  (clear_mask)
    );

    // youngest hit wins.
    ewb_lookup i_lookup (
        .entry_match_i (entry_match),
        .write_ptr_i   (write_ptr),
        .entry_data_i  (entry_data),
        .hit_o         (hit_o),
        .read_o        (read_o)
    );

endmodule : evict_buffer

/* verif/evict_buffer_checker.sv */
`timescale 1ns/10ps

module evict_buffer_checker (
    input  logic           clk,

    // expected values from the testbench table.
    input  logic           chk_lookup_i,
    input  logic           chk_state_i,
    input  int             lookup_test_i,
    input  int             state_test_i,
    input  logic           done_i,
    input  logic           exp_full_i,
    input  logic           exp_empty_i,
    input  logic           exp_head_i,
    input  ewb_pkg::line_t exp_data_i,
    input  ewb_pkg::addr_t exp_addr_i,
    input  logic           exp_hit_i,
    input  ewb_pkg::line_t exp_read_i,

    // DUT outputs.
    input  logic           full_i,
    input  logic           empty_i,
    input  ewb_pkg::line_t data_i,
    input  ewb_pkg::addr_t addr_i,
    input  logic           hit_i,
    input  ewb_pkg::line_t read_i,

    output int             error_count_o,
    output logic           finished_o
);

    import ewb_pkg::*;

    localparam int NUM_TESTS = 6;

    int   test_errors [NUM_TESTS+1] = '{default: 0};
    int   n_checks = 0;
    int   n_errors = 0;
    int   last_closed = 0;
    logic finished_q = 1'b0;

    function automatic string test_name(input int id);
        case (id)
            1: return "reset state";
            2: return "push and drain order";
            3: return "full and dropped push";
            4: return "tag lookup";
            5: return "lookup with replace";
            6: return "push and yumi together";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_bit(input int test, input string what, input logic exp, input logic got);
        if (got !== exp) begin
            $display("[FAIL] %0d ns test %0d %s: expected %b, got %b", $time, test, what, exp, got);
            test_errors[test]++;
            n_errors++;
        end
    endtask

    task automatic check_line(input int test, input string what, input line_t exp,
                              input line_t got);
        if (got !== exp) begin
            $display("[FAIL] %0d ns test %0d %s: expected %0h, got %0h",
                     $time, test, what, exp, got);
            test_errors[test]++;
            n_errors++;
        end
    endtask

    // a test is over once the state checks have moved past it.
    task automatic close_tests_before(input int upto);
        while (last_closed + 1 < upto) begin
            last_closed++;
            if (test_errors[last_closed] == 0) begin
                $display("test %0d %s: pass", last_closed, test_name(last_closed));
            end else begin
                $display("test %0d %s: %0d errors", last_closed, test_name(last_closed),
                         test_errors[last_closed]);
            end
        end
    endtask

    always @(posedge clk) begin
        if (chk_lookup_i) begin
            n_checks++;
            check_bit(lookup_test_i, "hit_o", exp_hit_i, hit_i);
            check_line(lookup_test_i, "read_o", exp_read_i, read_i);
        end
        if (chk_state_i) begin
            n_checks++;
            check_bit(state_test_i, "full_o", exp_full_i, full_i);
            check_bit(state_test_i, "empty_o", exp_empty_i, empty_i);
            if (exp_head_i) begin
                check_line(state_test_i, "data_o", exp_data_i, data_i);
                check_line(state_test_i, "addr_o", line_t'(exp_addr_i), line_t'(addr_i));
            end
            close_tests_before(state_test_i);
        end
        if (done_i && !finished_q) begin
            close_tests_before(NUM_TESTS + 1);
            $display("checks %0d, errors %0d", n_checks, n_errors);
            finished_q <= 1'b1;
        end
    end

    assign error_count_o = n_errors;
    assign finished_o    = finished_q;

endmodule : evict_buffer_checker

/* verif/evict_buffer_tb.sv */
`timescale 1ns/10ps

module evict_buffer_tb;

    import ewb_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int MARGIN_CYCLES = 20;
    // head id that is not checked.
    localparam int NC = 255;

    typedef enum logic [2:0] {
        OP_IDLE, OP_PUSH, OP_POP, OP_LOOK, OP_REPL, OP_PUSHPOP
    } op_e;

    // one table row; full to read_id are the expected values.
    typedef struct {
        int   test;
        op_e  op;
        int   data_id;
        int   addr_id;
        int   tag_id;
        int   rep_id;
        logic full;
        logic empty;
        int   head_data;
        int   head_addr;
        logic hit;
        int   read_id;
    } row_t;

    row_t rows [$];

    logic  clk = 1'b0;
    logic  rst;
    logic  valid;
    line_t push_data;
    addr_t push_addr;
    logic  full;
    logic  tag_check;
    tag_t  tag;
    logic  write_ewb;
    line_t replace;
    logic  hit;
    line_t read_line;
    logic  empty;
    line_t head_data;
    addr_t head_addr;
    logic  yumi;

    logic  chk_lookup;
    logic  chk_state;
    int    lookup_test;
    int    state_test;
    logic  done;
    logic  exp_full;
    logic  exp_empty;
    logic  exp_head;
    line_t exp_data;
    addr_t exp_addr;
    logic  exp_hit;
    line_t exp_read;
    int    error_count;
    logic  finished;
    logic  table_ready = 1'b0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // id 0 is the all-zero line.
    function automatic line_t make_line(input int id);
        line_t line;
        line = '0;
        if (id != 0) begin
            for (int w = 0; w < LINE_WIDTH / 32; w++) begin
                line[w*32 +: 32] = {8'(id) ^ 8'ha5, 8'(w), 16'(id * 4951 + w * 97)};
            end
        end
        return line;
    endfunction

    function automatic addr_t make_addr(input int id);
        return {27'h0ab_0000 + 27'(id), 5'(id * 3)};
    endfunction

    function automatic tag_t make_tag(input int id);
        addr_t a;
        a = make_addr(id);
        return a[31:TAG_LSB];
    endfunction

    task automatic add_row(input int test, input op_e op, input int d, input int a,
                           input int t, input int r, input logic e_full, input logic e_empty,
                           input int e_data, input int e_addr, input logic e_hit,
                           input int e_read);
        row_t row;
        row = '{test, op, d, a, t, r, e_full, e_empty, e_data, e_addr, e_hit, e_read};
        rows.push_back(row);
    endtask

    task automatic build_table();
        add_row(1, OP_IDLE,    0,  0,  0,   0, 0, 1, NC,  NC, 0,   0);
        add_row(1, OP_LOOK,    0,  0,  1,   0, 0, 1, NC,  NC, 0,   0);
        add_row(2, OP_PUSH,    1,  1,  0,   0, 0, 0,  1,   1, 0,   0);
        add_row(2, OP_PUSH,    2,  2,  0,   0, 0, 0,  1,   1, 0,   0);
        add_row(2, OP_PUSH,    3,  3,  0,   0, 0, 0,  1,   1, 0,   0);
        add_row(2, OP_POP,     0,  0,  0,   0, 0, 0,  2,   2, 0,   0);
        add_row(2, OP_POP,     0,  0,  0,   0, 0, 0,  3,   3, 0,   0);
        add_row(2, OP_POP,     0,  0,  0,   0, 0, 1, NC,  NC, 0,   0);
        add_row(2, OP_POP,     0,  0,  0,   0, 0, 1, NC,  NC, 0,   0);
        add_row(2, OP_PUSH,    4,  4,  0,   0, 0, 0,  4,   4, 0,   0);
        add_row(2, OP_POP,     0,  0,  0,   0, 0, 1, NC,  NC, 0,   0);
        // fill all eight slots, then push once more while full.
        add_row(3, OP_PUSH,    5,  5,  0,   0, 0, 0,  5,   5, 0,   0);
        add_row(3, OP_PUSH,    6,  6,  0,   0, 0, 0,  5,   5, 0,   0);
        add_row(3, OP_PUSH,    7,  7,  0,   0, 0, 0,  5,   5, 0,   0);
        add_row(3, OP_PUSH,    8,  8,  0,   0, 0, 0,  5,   5, 0,   0);
        add_row(3, OP_PUSH,    9,  9,  0,   0, 0, 0,  5,   5, 0,   0);
        add_row(3, OP_PUSH,   10, 10,  0,   0, 0, 0,  5,   5, 0,   0);
        add_row(3, OP_PUSH,   11, 11,  0,   0, 0, 0,  5,   5, 0,   0);
        add_row(3, OP_PUSH,   12, 12,  0,   0, 1, 0,  5,   5, 0,   0);
        add_row(3, OP_PUSH,   13, 13,  0,   0, 1, 0,  5,   5, 0,   0);
        add_row(3, OP_POP,     0,  0,  0,   0, 0, 0,  6,   6, 0,   0);
        add_row(3, OP_PUSH,   14, 14,  0,   0, 1, 0,  6,   6, 0,   0);
        add_row(3, OP_POP,     0,  0,  0,   0, 0, 0,  7,   7, 0,   0);
        add_row(3, OP_POP,     0,  0,  0,   0, 0, 0,  8,   8, 0,   0);
        add_row(3, OP_POP,     0,  0,  0,   0, 0, 0,  9,   9, 0,   0);
        add_row(3, OP_POP,     0,  0,  0,   0, 0, 0, 10,  10, 0,   0);
        add_row(3, OP_POP,     0,  0,  0,   0, 0, 0, 11,  11, 0,   0);
        add_row(3, OP_POP,     0,  0,  0,   0, 0, 0, 12,  12, 0,   0);
        add_row(3, OP_POP,     0,  0,  0,   0, 0, 0, 14,  14, 0,   0);
        add_row(3, OP_POP,     0,  0,  0,   0, 0, 1, NC,  NC, 0,   0);
        // lines 15, 17 and 18 share a tag.
        add_row(4, OP_PUSH,   15, 20,  0,   0, 0, 0, 15,  20, 0,   0);
        add_row(4, OP_PUSH,   16, 21,  0,   0, 0, 0, 15,  20, 0,   0);
        add_row(4, OP_PUSH,   17, 20,  0,   0, 0, 0, 15,  20, 0,   0);
        add_row(4, OP_LOOK,    0,  0, 21,   0, 0, 0, 15,  20, 1,  16);
        add_row(4, OP_LOOK,    0,  0, 20,   0, 0, 0, 15,  20, 1,  17);
        add_row(4, OP_LOOK,    0,  0, 22,   0, 0, 0, 15,  20, 0,   0);
        // a buffered tag without tag_check must not hit.
        add_row(4, OP_PUSH,   18, 20, 20,   0, 0, 0, 15,  20, 0,   0);
        add_row(4, OP_LOOK,    0,  0, 20,   0, 0, 0, 15,  20, 1,  18);
        add_row(5, OP_REPL,    0,  0, 20, 129, 0, 0, 129, 20, 1,  18);
        add_row(5, OP_LOOK,    0,  0, 20,   0, 0, 0, 129, 20, 1, 129);
        add_row(5, OP_LOOK,    0,  0, 21,   0, 0, 0, 129, 20, 1,  16);
        add_row(5, OP_POP,     0,  0,  0,   0, 0, 0, 16,  21, 0,   0);
        add_row(5, OP_POP,     0,  0,  0,   0, 0, 0, 129, 20, 0,   0);
        add_row(5, OP_POP,     0,  0,  0,   0, 0, 0, 129, 20, 0,   0);
        add_row(5, OP_POP,     0,  0,  0,   0, 0, 1, NC,  NC, 0,   0);
        add_row(6, OP_PUSH,   19, 30,  0,   0, 0, 0, 19,  30, 0,   0);
        add_row(6, OP_PUSH,   20, 31,  0,   0, 0, 0, 19,  30, 0,   0);
        add_row(6, OP_PUSHPOP, 21, 32, 0,   0, 0, 0, 20,  31, 0,   0);
        add_row(6, OP_PUSHPOP, 22, 33, 0,   0, 0, 0, 21,  32, 0,   0);
        add_row(6, OP_POP,     0,  0,  0,   0, 0, 0, 22,  33, 0,   0);
        add_row(6, OP_POP,     0,  0,  0,   0, 0, 1, NC,  NC, 0,   0);
    endtask

    task automatic drive_idle();
        valid     = 1'b0;
        push_data = '0;
        push_addr = '0;
        yumi      = 1'b0;
        tag_check = 1'b0;
        tag       = '0;
        write_ewb = 1'b0;
        replace   = '0;
    endtask

    // state left by row p, or the reset state when p is negative.
    task automatic expect_state(input int p);
        if (p < 0) begin
            exp_full   = 1'b0;
            exp_empty  = 1'b1;
            exp_head   = 1'b0;
            state_test = rows[0].test;
        end else begin
            exp_full   = rows[p].full;
            exp_empty  = rows[p].empty;
            exp_head   = (rows[p].head_data != NC);
            exp_data   = make_line(rows[p].head_data);
            exp_addr   = make_addr(rows[p].head_addr);
            state_test = rows[p].test;
        end
        chk_state = 1'b1;
    endtask

    task automatic apply_row(input int i);
        row_t cur;
        cur         = rows[i];
        valid       = (cur.op == OP_PUSH) || (cur.op == OP_PUSHPOP);
        push_data   = make_line(cur.data_id);
        push_addr   = make_addr(cur.addr_id);
        yumi        = (cur.op == OP_POP) || (cur.op == OP_PUSHPOP);
        tag_check   = (cur.op == OP_LOOK) || (cur.op == OP_REPL);
        tag         = make_tag(cur.tag_id);
        write_ewb   = (cur.op == OP_REPL);
        replace     = make_line(cur.rep_id);
        lookup_test = cur.test;
        exp_hit     = cur.hit;
        exp_read    = make_line(cur.read_id);
        chk_lookup  = 1'b1;
        expect_state(i - 1);
    endtask

    initial begin
        rst         = 1'b1;
        chk_lookup  = 1'b0;
        chk_state   = 1'b0;
        done        = 1'b0;
        lookup_test = 1;
        state_test  = 1;
        drive_idle();
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            @(negedge clk);
            apply_row(i);
        end
        // one more cycle shows the state left by the last row.
        @(negedge clk);
        drive_idle();
        chk_lookup = 1'b0;
        expect_state(rows.size() - 1);
        @(negedge clk);
        chk_state = 1'b0;
        done      = 1'b1;
        wait (finished);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #((rows.size() + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the checker finished");
        $display("ERRORS FOUND");
        $finish;
    end

    evict_buffer i_evict_buffer (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (valid),
        .data_i      (push_data),
        .addr_i      (push_addr),
        .full_o      (full),
        .tag_check_i (tag_check),
        .tag_i       (tag),
        .write_ewb_i (write_ewb),
        .replace_i   (replace),
        .hit_o       (hit),
        .read_o      (read_line),
        .empty_o     (empty),
        .data_o      (head_data),
        .addr_o      (head_addr),
        .yumi_i      (yumi)
    );

    evict_buffer_checker i_evict_buffer_checker (
        .clk           (clk),
        .chk_lookup_i  (chk_lookup),
        .chk_state_i   (chk_state),
        .lookup_test_i (lookup_test),
        .state_test_i  (state_test),
        .done_i        (done),
        .exp_full_i    (exp_full),
        .exp_empty_i   (exp_empty),
        .exp_head_i    (exp_head),
        .exp_data_i    (exp_data),
        .exp_addr_i    (exp_addr),
        .exp_hit_i     (exp_hit),
        .exp_read_i    (exp_read),
        .full_i        (full),
        .empty_i       (empty),
        .data_i        (head_data),
        .addr_i        (head_addr),
        .hit_i         (hit),
        .read_i        (read_line),
        .error_count_o (error_count),
        .finished_o    (finished)
    );

endmodule : evict_buffer_tb

/* build.f */
source/ewb_pkg.sv
source/ewb_entry.sv
source/ewb_alloc.sv
source/ewb_drain.sv
source/ewb_lookup.sv
source/evict_buffer.sv
verif/evict_buffer_checker.sv
verif/evict_buffer_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= evict_buffer_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
